//--- pcie_drv_pkg.sv
//--------------------------------------------------------------------------
// Shared TLP field layout and BAR0 register map of the endpoint driver
// Beat layout follows the 64-bit receive local-link of the core
// Only 3DW header memory writes are described, 4DW headers are not
// Register index is address bits 5:2, upper BAR0 bits alias
//--------------------------------------------------------------------------
`default_nettype none

package pcie_drv_pkg;

    //----------------------------------------------------------------------
    // TLP header fields
    //----------------------------------------------------------------------
    localparam logic [6:0] TLP_FMT_TYPE_MWR32 = 7'b10_00000; // 3DW MWr with data

    // DW0 and DW1 of a start beat
    typedef struct packed {
        logic        rsvd0;       // DW0 bit 31
        logic [6:0]  fmt_type;    // Fmt and type
        logic [13:0] misc;        // TC, TD, EP, attr and reserved
        logic [9:0]  length;      // Payload in DW
        logic [15:0] req_id;      // Requester id
        logic [7:0]  tag;
        logic [3:0]  last_be;
        logic [3:0]  first_be;
    } tlp_hdr_view_t;

    // DW2 and DW3 of the second beat of a 3DW write
    typedef struct packed {
        logic [31:0] addr;        // Byte address, bits 1:0 zero
        logic [31:0] data;        // Single write DW
    } tlp_ad_view_t;

    // One receive beat, decoded by position in the packet
    typedef union packed {
        tlp_hdr_view_t hdr;
        tlp_ad_view_t  ad;
    } rx_beat_t;

    //----------------------------------------------------------------------
    // BAR0 register map
    //----------------------------------------------------------------------
    localparam int REG_ADDR_W = 4;                          // DW index width

    localparam logic [REG_ADDR_W-1:0] REG_SW_POINTER = 4'd0; // Host ring pointer
    localparam logic [REG_ADDR_W-1:0] REG_IRQ_EN     = 4'd1; // Bit 0 enables irq
    localparam logic [REG_ADDR_W-1:0] REG_SECS       = 4'd2; // Seconds load
    localparam logic [REG_ADDR_W-1:0] REG_NSECS      = 4'd3; // Nanoseconds load
    localparam logic [REG_ADDR_W-1:0] REG_TS_EN      = 4'd4; // Bit 0 timestamp en

    //----------------------------------------------------------------------
    // Misc widths and constants
    //----------------------------------------------------------------------
    localparam int PTR_W = 32;                              // Ring pointer width

    localparam logic [31:0] NS_PER_SEC = 32'd1_000_000_000; // Wrap point of nsecs

endpackage

`default_nettype wire

//--- tlp_rx_decoder.sv
//--------------------------------------------------------------------------
// Receive local-link parser for host register writes on BAR0
// Accepts only 3DW memory writes of length 1 in exactly two beats
// Reads, 4DW headers, longer writes and other BARs are dropped silently
// Destination is always ready, so a beat counts on trn_rsrc_rdy_n low
// Output is registered, one write pulse per qualifying packet
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tlp_rx_decoder
    import pcie_drv_pkg::*;
(
    input  wire logic                  trn_clk,
    input  wire logic                  rst_n,
    input  wire rx_beat_t              trn_rd,          // Beat, view by position
    input  wire logic                  trn_rsof_n,
    input  wire logic                  trn_reof_n,
    input  wire logic                  trn_rsrc_rdy_n,
    input  wire logic                  trn_rsrc_dsc_n,  // Low abandons packet
    input  wire logic [6:0]            trn_rbar_hit_n,  // Bit 0 is BAR0
    output logic                       reg_wr_en,       // One-cycle pulse
    output logic [REG_ADDR_W-1:0]      reg_addr,        // DW index
    output logic [31:0]                reg_wr_data
);

    logic beat_ok;      // Beat transferred this cycle
    logic hdr_match;    // Start beat is a usable write
    logic wr_pending;   // Header accepted, waiting for data beat
    logic wr_fire;      // Data beat completes the write

    //----------------------------------------------------------------------
    // Beat qualification
    //----------------------------------------------------------------------
    assign beat_ok = ~trn_rsrc_rdy_n;

    // Single DW MWr32 to BAR0 that does not end on its first beat
    assign hdr_match = (trn_rd.hdr.fmt_type == TLP_FMT_TYPE_MWR32) &&
                       (trn_rd.hdr.length == 10'd1) &&
                       ~trn_rbar_hit_n[0] &&
                       trn_reof_n;

    // Second beat must also be the last one
    assign wr_fire = beat_ok && trn_rsrc_dsc_n && trn_rsof_n && ~trn_reof_n &&
                     wr_pending;

    //----------------------------------------------------------------------
    // Packet tracking
    //----------------------------------------------------------------------
    always_ff @(posedge trn_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pending <= 1'b0;
            reg_wr_en  <= 1'b0;
        end else begin
            reg_wr_en <= wr_fire;                   // Pulse, no acknowledge
            if (!trn_rsrc_dsc_n) begin
                wr_pending <= 1'b0;                 // Discontinue drops packet
            end else if (beat_ok) begin
                if (!trn_rsof_n) begin
                    wr_pending <= hdr_match;        // New packet starts
                end else begin
                    wr_pending <= 1'b0;             // Any later beat ends wait
                end
            end
        end
    end

    // Address and data view of the second beat
    always_ff @(posedge trn_clk) begin
        if (wr_fire) begin
            reg_addr    <= trn_rd.ad.addr[5:2];     // DW index in BAR0
            reg_wr_data <= trn_rd.ad.data;
        end
    end

endmodule

`default_nettype wire

//--- sys_time.sv
//--------------------------------------------------------------------------
// System time counters for receive timestamps
// Nanoseconds step by NS_PER_CYCLE each trn_clk cycle
// A host value of nsecs above NS_PER_SEC is reduced one second per cycle
// Register writes win over the step in the same cycle
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sys_time
    import pcie_drv_pkg::*;
#(
    parameter int unsigned NS_PER_CYCLE = 4                 // 250 MHz clock
) (
    input  wire logic                  trn_clk,
    input  wire logic                  rst_n,
    input  wire logic                  reg_wr_en,
    input  wire logic [REG_ADDR_W-1:0] reg_addr,
    input  wire logic [31:0]           reg_wr_data,
    output logic [31:0]                sys_nsecs,
    output logic [31:0]                sys_secs,
    output logic                       rx_timestamp_en
);

    logic [32:0] ns_sum;      // Next nsecs before wrap, carry kept
    logic [31:0] ns_rem;      // Remainder after one second
    logic        ns_wrap;     // Second boundary crossed
    logic        wr_secs;
    logic        wr_nsecs;
    logic        wr_ts_en;

    assign ns_sum  = {1'b0, sys_nsecs} + 33'(NS_PER_CYCLE);
    assign ns_rem  = ns_sum[31:0] - NS_PER_SEC;
    assign ns_wrap = (ns_sum >= {1'b0, NS_PER_SEC});

    assign wr_secs  = reg_wr_en && (reg_addr == REG_SECS);
    assign wr_nsecs = reg_wr_en && (reg_addr == REG_NSECS);
    assign wr_ts_en = reg_wr_en && (reg_addr == REG_TS_EN);

    //----------------------------------------------------------------------
    // Counters and timestamp enable
    //----------------------------------------------------------------------
    always_ff @(posedge trn_clk or negedge rst_n) begin
        if (!rst_n) begin
            sys_nsecs       <= 32'd0;
            sys_secs        <= 32'd0;
            rx_timestamp_en <= 1'b0;
        end else begin
            if (wr_nsecs) begin
                sys_nsecs <= reg_wr_data;           // Host load, no step
            end else if (ns_wrap) begin
                sys_nsecs <= ns_rem;                // Keep the remainder
            end else begin
                sys_nsecs <= ns_sum[31:0];
            end

            if (wr_secs) begin
                sys_secs <= reg_wr_data;
            end else if (ns_wrap && !wr_nsecs) begin
                sys_secs <= sys_secs + 32'd1;       // Carry from nsecs
            end

            if (wr_ts_en) begin
                rx_timestamp_en <= reg_wr_data[0];
            end
        end
    end

endmodule

`default_nettype wire

//--- interrupt_ctrl.sv
//--------------------------------------------------------------------------
// Ring interrupt controller with the core's cfg_interrupt handshake
// One interrupt per software pointer write, while pointers differ
// A started request is held until ready even if the enable drops
// A core that never gives ready stalls only this block
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module interrupt_ctrl
    import pcie_drv_pkg::*;
(
    input  wire logic                  trn_clk,
    input  wire logic                  rst_n,
    input  wire logic                  reg_wr_en,
    input  wire logic [REG_ADDR_W-1:0] reg_addr,
    input  wire logic [31:0]           reg_wr_data,
    input  wire logic [PTR_W-1:0]      hw_pointer,          // Hardware ring position
    input  wire logic                  cfg_interrupt_rdy_n, // Core takes request
    output logic                       cfg_interrupt_n      // Low while requesting
);

    logic [PTR_W-1:0] sw_pointer;   // Last position acked by the host
    logic             irq_en;       // Host interrupt enable
    logic             armed;        // Allowed one more interrupt
    logic             wr_sw_ptr;
    logic             wr_irq_en;
    logic             irq_req;      // Start a new request
    logic             hs_done;      // Core accepted the request

    //----------------------------------------------------------------------
    // Register decode and request rule
    //----------------------------------------------------------------------
    assign wr_sw_ptr = reg_wr_en && (reg_addr == REG_SW_POINTER);
    assign wr_irq_en = reg_wr_en && (reg_addr == REG_IRQ_EN);

    // Idle means no request on the core port
    assign irq_req = armed && irq_en && cfg_interrupt_n &&
                     (hw_pointer != sw_pointer);

    assign hs_done = ~cfg_interrupt_n && ~cfg_interrupt_rdy_n;

    //----------------------------------------------------------------------
    // Host registers
    //----------------------------------------------------------------------
    always_ff @(posedge trn_clk or negedge rst_n) begin
        if (!rst_n) begin
            sw_pointer <= '0;
            irq_en     <= 1'b0;
        end else begin
            if (wr_sw_ptr) begin
                sw_pointer <= reg_wr_data;          // Host progress
            end
            if (wr_irq_en) begin
                irq_en <= reg_wr_data[0];
            end
        end
    end

    //----------------------------------------------------------------------
    // Arming and handshake
    //----------------------------------------------------------------------
    always_ff @(posedge trn_clk or negedge rst_n) begin
        if (!rst_n) begin
            armed           <= 1'b1;                // Armed out of reset
            cfg_interrupt_n <= 1'b1;
        end else begin
            if (wr_sw_ptr) begin
                armed <= 1'b1;                      // New ack wins over disarm
            end else if (hs_done) begin
                armed <= 1'b0;                      // Wait for host ack
            end

            if (hs_done) begin
                cfg_interrupt_n <= 1'b1;            // Release next cycle
            end else if (irq_req) begin
                cfg_interrupt_n <= 1'b0;            // Hold until ready
            end
        end
    end

endmodule

`default_nettype wire

//--- pcie_endpoint_driver.sv
//--------------------------------------------------------------------------
// Endpoint driver control path reached through BAR0 writes
// Receive link is never back-pressured, trn_rdst_rdy_n is tied low
// No completions and no transmit path, so credits are not used
// Register value lands one cycle after the end beat of a write
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pcie_endpoint_driver
    import pcie_drv_pkg::*;
#(
    parameter int unsigned NS_PER_CYCLE = 4                 // 250 MHz clock
) (
    input  wire logic             trn_clk,
    input  wire logic             rst_n,
    // Receive local-link
    input  wire rx_beat_t         trn_rd,
    input  wire logic             trn_rsof_n,
    input  wire logic             trn_reof_n,
    input  wire logic             trn_rsrc_rdy_n,
    input  wire logic             trn_rsrc_dsc_n,
    output logic                  trn_rdst_rdy_n,
    input  wire logic [6:0]       trn_rbar_hit_n,
    // Ring and interrupt
    input  wire logic [PTR_W-1:0] hw_pointer,
    output logic                  cfg_interrupt_n,
    input  wire logic             cfg_interrupt_rdy_n,
    // System time
    output logic [31:0]           sys_nsecs,
    output logic [31:0]           sys_secs,
    output logic                  rx_timestamp_en
);

    logic                  reg_wr_en;     // Decoded write pulse
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [31:0]           reg_wr_data;

    assign trn_rdst_rdy_n = 1'b0;         // Always listening

    tlp_rx_decoder u_tlp_rx_decoder (
        .trn_clk        (trn_clk),
        .rst_n          (rst_n),
        .trn_rd         (trn_rd),
        .trn_rsof_n     (trn_rsof_n),
        .trn_reof_n     (trn_reof_n),
        .trn_rsrc_rdy_n (trn_rsrc_rdy_n),
        .trn_rsrc_dsc_n (trn_rsrc_dsc_n),
        .trn_rbar_hit_n (trn_rbar_hit_n),
        .reg_wr_en      (reg_wr_en),
        .reg_addr       (reg_addr),
        .reg_wr_data    (reg_wr_data)
    );

    sys_time #(
        .NS_PER_CYCLE (NS_PER_CYCLE)
    ) u_sys_time (
        .trn_clk         (trn_clk),
        .rst_n           (rst_n),
        .reg_wr_en       (reg_wr_en),
        .reg_addr        (reg_addr),
        .reg_wr_data     (reg_wr_data),
        .sys_nsecs       (sys_nsecs),
        .sys_secs        (sys_secs),
        .rx_timestamp_en (rx_timestamp_en)
    );

    interrupt_ctrl u_interrupt_ctrl (
        .trn_clk             (trn_clk),
        .rst_n               (rst_n),
        .reg_wr_en           (reg_wr_en),
        .reg_addr            (reg_addr),
        .reg_wr_data         (reg_wr_data),
        .hw_pointer          (hw_pointer),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n),
        .cfg_interrupt_n     (cfg_interrupt_n)
    );

endmodule

`default_nettype wire

//--- pcie_endpoint_driver_asserts.sv
//--------------------------------------------------------------------------
// Concurrent checks bound into the endpoint driver top level
// Uses the internal write pulse to tell host loads from counting
// Failure counts are summed for the testbench summary line
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pcie_endpoint_driver_asserts
    import pcie_drv_pkg::*;
#(
    parameter int unsigned NS_PER_CYCLE = 4
) (
    input  wire logic                  trn_clk,
    input  wire logic                  rst_n,
    input  wire logic                  reg_wr_en,
    input  wire logic [REG_ADDR_W-1:0] reg_addr,
    input  wire logic                  cfg_interrupt_n,
    input  wire logic                  cfg_interrupt_rdy_n,
    input  wire logic [31:0]           sys_nsecs,
    input  wire logic [31:0]           sys_secs
);

    logic [32:0] ns_sum;              // Next nsecs without a load
    logic        ns_load;             // Host writes nsecs
    logic        secs_load;           // Host writes secs
    logic        hs_seen;             // Handshake done, no pointer write since
    int          step_fails  = 0;
    int          wrap_fails  = 0;
    int          irq_fails   = 0;
    int          rearm_fails = 0;
    int          fail_count;

    assign ns_sum     = {1'b0, sys_nsecs} + 33'(NS_PER_CYCLE);
    assign ns_load    = reg_wr_en && (reg_addr == REG_NSECS);
    assign secs_load  = reg_wr_en && (reg_addr == REG_SECS);
    assign fail_count = step_fails + wrap_fails + irq_fails + rearm_fails;

    always_ff @(posedge trn_clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_seen <= 1'b0;
        end else if (reg_wr_en && (reg_addr == REG_SW_POINTER)) begin
            hs_seen <= 1'b0;                            // Host ack rearms
        end else if (!cfg_interrupt_n && !cfg_interrupt_rdy_n) begin
            hs_seen <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Time counters
    // ------------------------------------------------------------------------
    a_nsecs_step: assert property (@(posedge trn_clk) disable iff (!rst_n)
        !ns_load && (ns_sum < {1'b0, NS_PER_SEC}) |=> sys_nsecs == $past(ns_sum[31:0]))
        else begin
            step_fails++;
            $error("sys_nsecs did not advance by NS_PER_CYCLE");
        end

    a_nsecs_wrap: assert property (@(posedge trn_clk) disable iff (!rst_n)
        !ns_load && !secs_load && (ns_sum >= {1'b0, NS_PER_SEC}) |=>
        (sys_nsecs == $past(ns_sum[31:0] - NS_PER_SEC)) && (sys_secs == $past(sys_secs) + 32'd1))
        else begin
            wrap_fails++;
            $error("Second wrap left wrong sys_nsecs or sys_secs");
        end

    // ------------------------------------------------------------------------
    // Interrupt handshake
    // ------------------------------------------------------------------------
    a_irq_hold_release: assert property (@(posedge trn_clk) disable iff (!rst_n)
        !cfg_interrupt_n |=> cfg_interrupt_n == !$past(cfg_interrupt_rdy_n))
        else begin
            irq_fails++;
            $error("cfg_interrupt_n not held until ready or not released after it");
        end

    a_irq_rearm: assert property (@(posedge trn_clk) disable iff (!rst_n)
        hs_seen |-> cfg_interrupt_n)
        else begin
            rearm_fails++;
            $error("New interrupt before the software pointer was rewritten");
        end

endmodule

bind pcie_endpoint_driver pcie_endpoint_driver_asserts #(
    .NS_PER_CYCLE (NS_PER_CYCLE)
) u_asserts (.*);

`default_nettype wire

//--- tb_pcie_endpoint_driver.sv
//--------------------------------------------------------------------------
// Testbench for the endpoint driver at the default NS_PER_CYCLE
// Inputs change on the falling edge, outputs are sampled there too
// Port timing rules live in the bound assertion module
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_pcie_endpoint_driver
    import pcie_drv_pkg::*;
();

    localparam int CLK_HALF_NS = 4;                     // 8 ns period
    localparam int NS_STEP     = 4;                     // Default NS_PER_CYCLE
    // Reset and idle, 14 writes of 4 cycles, 2 handshakes, 3 quiet waits
    localparam int TEST_CYCLES = 25 + 14 * 4 + 2 * 18 + 3 * 12;

    logic             trn_clk = 1'b0;
    logic             rst_n;
    rx_beat_t         trn_rd;
    logic             trn_rsof_n;
    logic             trn_reof_n;
    logic             trn_rsrc_rdy_n;
    logic             trn_rsrc_dsc_n;
    logic             trn_rdst_rdy_n;
    logic [6:0]       trn_rbar_hit_n;
    logic [PTR_W-1:0] hw_pointer;
    logic             cfg_interrupt_n;
    logic             cfg_interrupt_rdy_n;
    logic [31:0]      sys_nsecs;
    logic [31:0]      sys_secs;
    logic             rx_timestamp_en;

    logic [31:0]      lcg_state = 32'h2cbc;             // Fixed seed
    logic [31:0]      model_secs;                       // Expected seconds
    logic [PTR_W-1:0] model_sw_ptr;                     // Expected sw pointer
    int               errors      = 0;
    int               tests_run   = 0;
    int               errors_seen = 0;                  // Failures before this test

    always #(CLK_HALF_NS) trn_clk = ~trn_clk;

    pcie_endpoint_driver u_pcie_endpoint_driver (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %0t ns %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic test_done(input string name);
        int fails_now;
        fails_now = errors + u_pcie_endpoint_driver.u_asserts.fail_count;
        tests_run++;
        $display("%-16s %s", name, (fails_now == errors_seen) ? "passed" : "failed");
        errors_seen = fails_now;
    endtask

    // Sends a two-beat TLP and returns once a matching write is visible
    task automatic send_tlp(input logic [6:0] fmt, input logic [9:0] len, input logic bar0,
                            input logic [3:0] idx, input logic [31:0] data, input logic cut);
        rx_beat_t hdr_beat;
        rx_beat_t ad_beat;
        hdr_beat              = '0;
        hdr_beat.hdr.fmt_type = fmt;
        hdr_beat.hdr.length   = len;
        hdr_beat.hdr.first_be = 4'hf;
        ad_beat.ad.addr       = {26'd0, idx, 2'b00};
        ad_beat.ad.data       = data;
        @(negedge trn_clk);
        trn_rd         = hdr_beat;                      // Start beat
        trn_rsof_n     = 1'b0;
        trn_rsrc_rdy_n = 1'b0;
        trn_rbar_hit_n = bar0 ? 7'b111_1110 : 7'b111_1101;
        @(negedge trn_clk);
        trn_rd         = ad_beat;                       // End beat
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b0;
        trn_rsrc_dsc_n = ~cut;
        @(negedge trn_clk);
        trn_rsrc_rdy_n = 1'b1;
        trn_reof_n     = 1'b1;
        trn_rsrc_dsc_n = 1'b1;
        trn_rbar_hit_n = 7'h7f;
        @(negedge trn_clk);                             // Register loaded by now
    endtask

    task automatic reg_write(input logic [3:0] idx, input logic [31:0] data);
        send_tlp(TLP_FMT_TYPE_MWR32, 10'd1, 1'b1, idx, data, 1'b0);
    endtask

    task automatic irq_handshake();
        int wait_cycles;
        int ready_delay;
        wait_cycles = 0;
        while (cfg_interrupt_n && wait_cycles < 10) begin
            @(negedge trn_clk);
            wait_cycles++;
        end
        assert (!cfg_interrupt_n) else begin
            $display("Interrupt request did not appear within 10 cycles at %0t ns", $time);
            errors++;
        end
        ready_delay = int'(lcg_next() % 32'd8);
        repeat (ready_delay) @(negedge trn_clk);      // Request must hold meanwhile
        cfg_interrupt_rdy_n = 1'b0;
        @(negedge trn_clk);
        cfg_interrupt_rdy_n = 1'b1;
        check("cfg_interrupt_n", 32'(cfg_interrupt_n), 32'd1);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge trn_clk);
            check("cfg_interrupt_n", 32'(cfg_interrupt_n), 32'd1);
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] ns_val;
        int          assert_fails;
        rst_n               = 1'b0;
        trn_rd              = '0;
        trn_rsof_n          = 1'b1;
        trn_reof_n          = 1'b1;
        trn_rsrc_rdy_n      = 1'b1;
        trn_rsrc_dsc_n      = 1'b1;
        trn_rbar_hit_n      = 7'h7f;
        hw_pointer          = '0;
        cfg_interrupt_rdy_n = 1'b1;
        model_secs          = 32'd0;
        model_sw_ptr        = '0;

        repeat (3) @(negedge trn_clk);
        check("cfg_interrupt_n", 32'(cfg_interrupt_n), 32'd1);
        check("rx_timestamp_en", 32'(rx_timestamp_en), 32'd0);
        check("trn_rdst_rdy_n", 32'(trn_rdst_rdy_n), 32'd0);
        check("sys_nsecs", sys_nsecs, 32'd0);
        check("sys_secs", sys_secs, model_secs);
        rst_n = 1'b1;
        repeat (20) @(negedge trn_clk);                 // Free running nsecs
        test_done("reset_state");

        model_secs = lcg_next();
        reg_write(REG_SECS, model_secs);
        check("sys_secs", sys_secs, model_secs);
        ns_val = NS_PER_SEC - 32'd1 - (lcg_next() % 32'd4);    // Wraps on next step
        reg_write(REG_NSECS, ns_val);
        check("sys_nsecs", sys_nsecs, ns_val);
        @(negedge trn_clk);
        model_secs = model_secs + 32'd1;
        check("sys_nsecs", sys_nsecs, ns_val + NS_STEP - NS_PER_SEC);
        check("sys_secs", sys_secs, model_secs);
        test_done("time_load");

        reg_write(REG_TS_EN, 32'd1);
        check("rx_timestamp_en", 32'(rx_timestamp_en), 32'd1);
        reg_write(REG_TS_EN, 32'd0);
        check("rx_timestamp_en", 32'(rx_timestamp_en), 32'd0);
        check("trn_rdst_rdy_n", 32'(trn_rdst_rdy_n), 32'd0);
        test_done("timestamp_en");

        hw_pointer = lcg_next() | 32'd1;                // Differs from sw pointer 0
        reg_write(REG_IRQ_EN, 32'd1);
        irq_handshake();
        expect_quiet(12);                               // Disarmed until host ack
        model_sw_ptr = hw_pointer + 32'd1;
        reg_write(REG_SW_POINTER, model_sw_ptr);
        irq_handshake();
        test_done("irq_handshake");

        model_sw_ptr = hw_pointer;
        reg_write(REG_SW_POINTER, model_sw_ptr);        // Pointers equal
        expect_quiet(12);
        reg_write(REG_IRQ_EN, 32'd0);
        model_sw_ptr = hw_pointer + 32'd2;
        reg_write(REG_SW_POINTER, model_sw_ptr);        // Armed but disabled
        expect_quiet(12);
        test_done("irq_blocked");

        send_tlp(TLP_FMT_TYPE_MWR32, 10'd1, 1'b0, REG_SECS, lcg_next(), 1'b0); // Other BAR
        send_tlp(7'h00, 10'd1, 1'b1, REG_SECS, lcg_next(), 1'b0);              // MRd32
        send_tlp(TLP_FMT_TYPE_MWR32, 10'd2, 1'b1, REG_SECS, lcg_next(), 1'b0); // Two DW
        send_tlp(TLP_FMT_TYPE_MWR32, 10'd1, 1'b1, REG_SECS, lcg_next(), 1'b1); // Cut
        check("sys_secs", sys_secs, model_secs);
        data = lcg_next();
        reg_write(REG_SECS, data);                      // Parser still in sync
        check("sys_secs", sys_secs, data);
        test_done("filtered_tlps");

        assert_fails = u_pcie_endpoint_driver.u_asserts.fail_count;
        $display("Tests: %0d, check errors: %0d, assertion failures: %0d",
                 tests_run, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Twice the expected run length
    initial begin
        #(2 * TEST_CYCLES * 2 * CLK_HALF_NS);
        $display("Watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
pcie_drv_pkg.sv
tlp_rx_decoder.sv
sys_time.sv
interrupt_ctrl.sv
pcie_endpoint_driver.sv
pcie_endpoint_driver_asserts.sv
tb_pcie_endpoint_driver.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the endpoint driver testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module tb_pcie_endpoint_driver \
    -f files.f -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "Build or simulation returned an error"
grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" || { cat sim.log; exit 1; }
